// ==== rtl/pat_pkg.sv ====
`default_nettype none

package pat_pkg;

	// ==============================
	// widths
	// ==============================
	localparam int DATA_WIDTH = 8;	// acc, field data and memory words; immediates are 8 bits
	localparam int INSTR_WIDTH = 20;
	localparam int FIELDP_WIDTH = 5;	// field pointer
	localparam int BUFP_WIDTH = 3;	// buffer pointer

	// instruction word, from the top bit down
	localparam int FIELDP_LSB = 15;	// field pointer next, 19:15
	localparam int COND_LSB = 13;	// condition, 14:13
	localparam int COND_WIDTH = 2;
	localparam int FIELD_OP_BIT = 12;	// 0 acc op, 1 field op
	localparam int OP8_LSB = 8;	// i8 opcode, 11:8
	localparam int OP3_LSB = 4;	// i3 opcode lives in imm 7:4, i0 opcode in imm 3:0
	localparam int OPCODE_WIDTH = 4;
	localparam int IMM3_WIDTH = 3;	// i3 immediate, imm 2:0

	// ==============================
	// opcodes
	// ==============================
	typedef enum logic [OPCODE_WIDTH-1:0] {
		I8_OR = 4'h0,
		I8_AND = 4'h1,
		I8_ADDM = 4'h2,
		I8_SUBM = 4'h3,
		I8_ADD = 4'h4,
		I8_SUB = 4'h5,
		I8_LDI = 4'h6,
		I8_LDM = 4'h7,
		I8_BF = 4'h8,
		I8_STM = 4'hb,
		I8_ORM = 4'hd,
		I8_ANDM = 4'he,
		I8_PREFIX_I3 = 4'hf	// escape into the i3 space
	} opcode_i8_e;

	typedef enum logic [OPCODE_WIDTH-1:0] {
		I3_SHL = 4'h0,
		I3_SHLO = 4'h1,
		I3_SHR = 4'h2,
		I3_ASR = 4'h3,
		I3_IN = 4'h5,
		I3_OUT = 4'h8,
		I3_SETB = 4'h9,
		I3_PREFIX_I0 = 4'hf	// escape into the i0 space
	} opcode_i3_e;

	typedef enum logic [OPCODE_WIDTH-1:0] {
		I0_NOT = 4'h0,
		I0_MOV = 4'h1,
		I0_TEST = 4'h2,
		I0_NOP = 4'hf
	} opcode_i0_e;

	// ==============================
	// stage 2 controls
	// ==============================
	typedef enum logic [3:0] {
		ALU_OR, ALU_AND, ALU_NOT,
		ALU_ADD, ALU_SUB,
		ALU_SHL, ALU_SHLO, ALU_SHR, ALU_ASR,
		ALU_PASS_B	// ldi and ldm
	} alu_op_e;

	typedef enum logic [1:0] {
		SRC_ALU,	// own alu result
		SRC_INPUT,	// i_inputs
		SRC_CROSS	// field value into acc, acc into field
	} src_e;

	// code 3 is treated as always
	typedef enum logic [COND_WIDTH-1:0] {
		COND_ALWAYS = 2'd0,
		COND_NEG = 2'd1,
		COND_ZERO = 2'd2
	} cond_e;

	localparam logic [INSTR_WIDTH-1:0] INSTR_NOP = 20'h00fff;	// i0 nop, fieldp 0, always

endpackage

`default_nettype wire

// ==== rtl/pat_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

// one alu, used for both the acc side and the field side
module pat_alu (
	input wire [pat_pkg::DATA_WIDTH-1:0] i_a,	// acc or field value
	input wire [pat_pkg::DATA_WIDTH-1:0] i_b,	// immediate or memory word
	input wire pat_pkg::alu_op_e i_op,
	output logic [pat_pkg::DATA_WIDTH-1:0] o_y
);

	localparam int SHAMT_WIDTH = $clog2(pat_pkg::DATA_WIDTH);

	logic [SHAMT_WIDTH-1:0] shamt;
	logic [pat_pkg::DATA_WIDTH-1:0] ones_fill;	// low bits vacated by a left shift

	assign shamt = i_b[SHAMT_WIDTH-1:0];
	assign ones_fill = ~({pat_pkg::DATA_WIDTH{1'b1}} << shamt);

	always_comb
	begin
		case (i_op)
			pat_pkg::ALU_OR: o_y = i_a | i_b;
			pat_pkg::ALU_AND: o_y = i_a & i_b;
			pat_pkg::ALU_NOT: o_y = ~i_a;
			pat_pkg::ALU_ADD: o_y = i_a + i_b;	// wraps
			pat_pkg::ALU_SUB: o_y = i_a - i_b;
			pat_pkg::ALU_SHL: o_y = i_a << shamt;
			pat_pkg::ALU_SHLO: o_y = (i_a << shamt) | ones_fill;
			pat_pkg::ALU_SHR: o_y = i_a >> shamt;
			pat_pkg::ALU_ASR: o_y = $signed(i_a) >>> shamt;	// keeps the sign
			default: o_y = i_b;	// pass b for ldi, ldm
		endcase
	end

endmodule

`default_nettype wire

// ==== rtl/pat_data_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

// small data ram, combinational read, write on the clock edge
module pat_data_mem #(
	parameter int DMEM_ADR_WIDTH = 3
) (
	input wire clk,
	input wire [DMEM_ADR_WIDTH-1:0] i_rd_adr,
	output logic [pat_pkg::DATA_WIDTH-1:0] o_rd_data,
	input wire i_we,
	input wire [DMEM_ADR_WIDTH-1:0] i_wr_adr,
	input wire [pat_pkg::DATA_WIDTH-1:0] i_wr_data
);

	logic [pat_pkg::DATA_WIDTH-1:0] mem [2**DMEM_ADR_WIDTH];

	assign o_rd_data = mem[i_rd_adr];	// sees a write from the previous edge

	always_ff @(posedge clk)
	begin
		if (i_we)
			mem[i_wr_adr] <= i_wr_data;
	end

endmodule

`default_nettype wire

// ==== rtl/pat_program_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

// pc steps by one, or by the signed offset on a forward branch
module pat_program_counter #(
	parameter int I_ADR_WIDTH = 10	// must exceed the data width
) (
	input wire clk,
	input wire reset,
	input wire i_branch,
	input wire [pat_pkg::DATA_WIDTH-1:0] i_offset,
	output logic [I_ADR_WIDTH-1:0] o_pc
);

	logic [I_ADR_WIDTH-1:0] offset_ext;

	assign offset_ext = {{(I_ADR_WIDTH-pat_pkg::DATA_WIDTH){i_offset[pat_pkg::DATA_WIDTH-1]}},
		i_offset};

	always_ff @(posedge clk)
	begin
		if (reset)
			o_pc <= '0;
		else if (i_branch)
			o_pc <= o_pc + offset_ext;
		else
			o_pc <= o_pc + I_ADR_WIDTH'(1);
	end

endmodule

`default_nettype wire

// ==== rtl/pat_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

// stage 1: instruction register and decode, stage 2 controls registered one edge later
module pat_decoder #(
	parameter int DMEM_ADR_WIDTH = 3,
	parameter int FIELD_LATENCY = 4	// field read to write distance
) (
	input wire clk,
	input wire reset,
	input wire [pat_pkg::INSTR_WIDTH-1:0] i_instruction,
	input wire [pat_pkg::DATA_WIDTH-1:0] i_mem_data,	// async read of o_mem_rd_adr
	input wire [pat_pkg::DATA_WIDTH-1:0] i_field_in_low,
	input wire [pat_pkg::DATA_WIDTH-1:0] i_field_in_high,
	input wire i_field_sel,	// 1 picks the high buffer
	output logic o_branch,
	output logic [pat_pkg::DATA_WIDTH-1:0] o_offset,
	output logic [DMEM_ADR_WIDTH-1:0] o_mem_rd_adr,
	output pat_pkg::alu_op_e o_alu_op,
	output logic [pat_pkg::DATA_WIDTH-1:0] o_operand_b,
	output logic [pat_pkg::DATA_WIDTH-1:0] o_field_value,
	output logic o_dest_acc,
	output logic o_dest_field,
	output logic o_store,
	output logic o_out,
	output logic o_setb,
	output logic o_test,
	output pat_pkg::src_e o_src,
	output pat_pkg::cond_e o_cond,
	output logic [pat_pkg::DATA_WIDTH-1:0] o_imm,
	output logic [pat_pkg::FIELDP_WIDTH-1:0] o_fieldp,
	output logic [pat_pkg::FIELDP_WIDTH-1:0] o_fieldwp
);

	logic [pat_pkg::INSTR_WIDTH-1:0] instr_r;	// stage 1 register
	logic [pat_pkg::DATA_WIDTH-1:0] imm8;
	logic field_op;
	pat_pkg::opcode_i8_e op8;
	pat_pkg::opcode_i3_e op3;
	pat_pkg::opcode_i0_e op0;
	logic is_i8;
	logic is_i3;

	pat_pkg::alu_op_e alu_op;
	pat_pkg::src_e src;
	logic dest_reg;	// writes acc or field_out
	logic use_mem;	// operand b comes from data memory
	logic store;
	logic out_en;
	logic setb;
	logic test;
	logic [pat_pkg::DATA_WIDTH-1:0] operand_b;
	logic [pat_pkg::FIELDP_WIDTH-1:0] fieldp_hist [FIELD_LATENCY];

	// ==============================
	// split the word
	// ==============================
	assign imm8 = instr_r[pat_pkg::DATA_WIDTH-1:0];
	assign field_op = instr_r[pat_pkg::FIELD_OP_BIT];
	assign op8 = pat_pkg::opcode_i8_e'(instr_r[pat_pkg::OP8_LSB +: pat_pkg::OPCODE_WIDTH]);
	assign op3 = pat_pkg::opcode_i3_e'(imm8[pat_pkg::OP3_LSB +: pat_pkg::OPCODE_WIDTH]);
	assign op0 = pat_pkg::opcode_i0_e'(imm8[pat_pkg::OPCODE_WIDTH-1:0]);
	assign is_i8 = (op8 != pat_pkg::I8_PREFIX_I3);
	assign is_i3 = !is_i8 && (op3 != pat_pkg::I3_PREFIX_I0);

	assign use_mem = is_i8 && (op8 inside {pat_pkg::I8_ORM, pat_pkg::I8_ANDM,
		pat_pkg::I8_ADDM, pat_pkg::I8_SUBM, pat_pkg::I8_LDM});

	assign o_offset = imm8;	// bf offset, sign extended in the pc
	assign o_mem_rd_adr = imm8[DMEM_ADR_WIDTH-1:0];

	// one alu op, one source and one destination set per opcode
	always_comb
	begin
		alu_op = pat_pkg::ALU_PASS_B;	// don't care when nothing is written
		src = pat_pkg::SRC_ALU;
		dest_reg = 1'b1;	// most ops write a register
		store = 1'b0;
		out_en = 1'b0;
		setb = 1'b0;
		test = 1'b0;
		o_branch = 1'b0;
		if (is_i8)
		begin
			case (op8)
				pat_pkg::I8_OR, pat_pkg::I8_ORM: alu_op = pat_pkg::ALU_OR;
				pat_pkg::I8_AND, pat_pkg::I8_ANDM: alu_op = pat_pkg::ALU_AND;
				pat_pkg::I8_ADD, pat_pkg::I8_ADDM: alu_op = pat_pkg::ALU_ADD;
				pat_pkg::I8_SUB, pat_pkg::I8_SUBM: alu_op = pat_pkg::ALU_SUB;
				pat_pkg::I8_LDI, pat_pkg::I8_LDM: alu_op = pat_pkg::ALU_PASS_B;
				pat_pkg::I8_STM:
				begin
					dest_reg = 1'b0;
					store = 1'b1;
				end
				pat_pkg::I8_BF:
				begin
					dest_reg = 1'b0;
					o_branch = 1'b1;	// o_jump, pc takes the offset next edge
				end
				default: dest_reg = 1'b0;	// dropped bb, call and setsp codes
			endcase
		end
		else if (is_i3)
		begin
			case (op3)
				pat_pkg::I3_SHL: alu_op = pat_pkg::ALU_SHL;
				pat_pkg::I3_SHLO: alu_op = pat_pkg::ALU_SHLO;
				pat_pkg::I3_SHR: alu_op = pat_pkg::ALU_SHR;
				pat_pkg::I3_ASR: alu_op = pat_pkg::ALU_ASR;
				pat_pkg::I3_IN: src = pat_pkg::SRC_INPUT;
				pat_pkg::I3_OUT:
				begin
					dest_reg = 1'b0;
					out_en = 1'b1;
				end
				pat_pkg::I3_SETB:
				begin
					dest_reg = 1'b0;
					setb = 1'b1;
				end
				default: dest_reg = 1'b0;	// sp ops are gone
			endcase
		end
		else
		begin	// i0 class
			case (op0)
				pat_pkg::I0_NOT: alu_op = pat_pkg::ALU_NOT;
				pat_pkg::I0_MOV: src = pat_pkg::SRC_CROSS;	// direction set by field_op
				pat_pkg::I0_TEST:
				begin
					dest_reg = 1'b0;
					test = 1'b1;
				end
				default: dest_reg = 1'b0;	// nop and dropped codes
			endcase
		end
		// stm and test look at the field value on a field op
		if (field_op && (store || test))
			src = pat_pkg::SRC_CROSS;
	end

	always_comb
	begin
		if (use_mem)
			operand_b = i_mem_data;
		else if (is_i8)
			operand_b = imm8;
		else	// i3 immediate, zero extended
			operand_b = {{(pat_pkg::DATA_WIDTH-pat_pkg::IMM3_WIDTH){1'b0}},
				imm8[pat_pkg::IMM3_WIDTH-1:0]};
	end

	// ==============================
	// registers
	// ==============================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			instr_r <= pat_pkg::INSTR_NOP;
			o_dest_acc <= 1'b0;	// stage 2 idles as a nop
			o_dest_field <= 1'b0;
			o_store <= 1'b0;
			o_out <= 1'b0;
			o_setb <= 1'b0;
			o_test <= 1'b0;
			o_cond <= pat_pkg::COND_ALWAYS;
			o_fieldp <= '0;
			o_fieldwp <= '0;
			for (int i = 0; i < FIELD_LATENCY; i++)
				fieldp_hist[i] <= '0;
		end
		else
		begin
			instr_r <= i_instruction;
			o_dest_acc <= dest_reg && !field_op;
			o_dest_field <= dest_reg && field_op;
			o_store <= store;
			o_out <= out_en;
			o_setb <= setb;
			o_test <= test;
			o_cond <= pat_pkg::cond_e'(instr_r[pat_pkg::COND_LSB +: pat_pkg::COND_WIDTH]);
			o_fieldp <= instr_r[pat_pkg::FIELDP_LSB +: pat_pkg::FIELDP_WIDTH];
			// write pointer trails o_fieldp by FIELD_LATENCY+1
			fieldp_hist[0] <= o_fieldp;
			for (int i = 1; i < FIELD_LATENCY; i++)
				fieldp_hist[i] <= fieldp_hist[i-1];
			o_fieldwp <= fieldp_hist[FIELD_LATENCY-1];
		end
	end

	// stage 2 payload
	always_ff @(posedge clk)
	begin
		o_alu_op <= alu_op;
		o_src <= src;
		o_operand_b <= operand_b;
		o_imm <= imm8;
		o_field_value <= i_field_sel ? i_field_in_high : i_field_in_low;	// select before this edge
	end

endmodule

`default_nettype wire

// ==== rtl/pat_commit.sv ====
`timescale 1ns/1ps
`default_nettype none

// stage 2 commit: condition check, result select and architectural state
module pat_commit #(
	parameter int DMEM_ADR_WIDTH = 3
) (
	input wire clk,
	input wire reset,
	input wire [pat_pkg::DATA_WIDTH-1:0] i_acc_result,
	input wire [pat_pkg::DATA_WIDTH-1:0] i_field_result,
	input wire [pat_pkg::DATA_WIDTH-1:0] i_field_value,	// sampled field word
	input wire [pat_pkg::DATA_WIDTH-1:0] i_inputs,
	input wire i_dest_acc,
	input wire i_dest_field,
	input wire i_store,
	input wire i_out,
	input wire i_setb,
	input wire i_test,
	input wire pat_pkg::src_e i_src,
	input wire pat_pkg::cond_e i_cond,
	input wire [pat_pkg::DATA_WIDTH-1:0] i_imm,
	output logic [pat_pkg::DATA_WIDTH-1:0] o_acc,
	output logic [pat_pkg::DATA_WIDTH-1:0] o_field_out,
	output logic o_field_we_low,
	output logic o_field_we_high,
	output logic o_field_sel,	// low/high buffer select
	output logic [pat_pkg::BUFP_WIDTH-1:0] o_bufp,
	output logic [pat_pkg::DATA_WIDTH-1:0] o_outputs,
	output logic o_mem_we,
	output logic [DMEM_ADR_WIDTH-1:0] o_mem_wr_adr,
	output logic [pat_pkg::DATA_WIDTH-1:0] o_mem_wr_data
);

	logic z_flag;
	logic n_flag;
	logic cond_ok;
	logic [pat_pkg::DATA_WIDTH-1:0] acc_next;
	logic [pat_pkg::DATA_WIDTH-1:0] field_next;
	logic [pat_pkg::DATA_WIDTH-1:0] side_value;	// stm data and test operand

	// ==============================
	// condition and result select
	// ==============================
	always_comb
	begin
		case (i_cond)
			pat_pkg::COND_NEG: cond_ok = n_flag;
			pat_pkg::COND_ZERO: cond_ok = z_flag;
			default: cond_ok = 1'b1;	// always, also code 3
		endcase
	end

	always_comb
	begin
		case (i_src)
			pat_pkg::SRC_INPUT:
			begin
				acc_next = i_inputs;
				field_next = i_inputs;
			end
			pat_pkg::SRC_CROSS:
			begin
				acc_next = i_field_value;	// mov field to acc
				field_next = o_acc;	// mov acc to field
			end
			default:
			begin
				acc_next = i_acc_result;
				field_next = i_field_result;
			end
		endcase
	end

	// the cross source marks a field stm or field test
	assign side_value = (i_src == pat_pkg::SRC_CROSS) ? i_field_value : o_acc;

	// memory write lands on the commit edge itself
	assign o_mem_we = i_store && cond_ok;
	assign o_mem_wr_adr = i_imm[DMEM_ADR_WIDTH-1:0];
	assign o_mem_wr_data = side_value;

	// ==============================
	// state update
	// ==============================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			o_acc <= '0;
			o_field_out <= '0;
			o_field_we_low <= 1'b0;
			o_field_we_high <= 1'b0;
			o_field_sel <= 1'b0;
			o_bufp <= '0;
			o_outputs <= '0;
			z_flag <= 1'b0;
			n_flag <= 1'b0;
		end
		else
		begin
			// one cycle strobe on the side selected at commit
			o_field_we_low <= i_dest_field && cond_ok && !o_field_sel;
			o_field_we_high <= i_dest_field && cond_ok && o_field_sel;
			if (cond_ok)
			begin
				if (i_dest_acc)
					o_acc <= acc_next;
				if (i_dest_field)
					o_field_out <= field_next;
				if (i_out)
					o_outputs <= o_acc;
				if (i_setb)
				begin
					o_bufp <= i_imm[pat_pkg::BUFP_WIDTH-1:0];
					o_field_sel <= i_imm[pat_pkg::BUFP_WIDTH];	// imm bit 3
				end
				if (i_test)
				begin
					z_flag <= (side_value == '0);
					n_flag <= side_value[pat_pkg::DATA_WIDTH-1];
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/pat_core.sv ====
`timescale 1ns/1ps
`default_nettype none

// accumulator core, two stages: decode, then twin alus and commit
module pat_core #(
	parameter int I_ADR_WIDTH = 10,
	parameter int DMEM_ADR_WIDTH = 3,	// eight data words
	parameter int FIELD_LATENCY = 4
) (
	input wire clk,
	input wire reset,
	input wire [pat_pkg::INSTR_WIDTH-1:0] i_instruction,
	input wire [pat_pkg::DATA_WIDTH-1:0] i_field_in_low,
	input wire [pat_pkg::DATA_WIDTH-1:0] i_field_in_high,
	input wire [pat_pkg::DATA_WIDTH-1:0] i_inputs,
	output wire [I_ADR_WIDTH-1:0] o_pc,
	output wire o_jump,
	output wire [pat_pkg::BUFP_WIDTH-1:0] o_bufp,
	output wire [pat_pkg::FIELDP_WIDTH-1:0] o_fieldp,
	output wire [pat_pkg::FIELDP_WIDTH-1:0] o_fieldwp,
	output wire o_field_we_low,
	output wire o_field_we_high,
	output wire [pat_pkg::DATA_WIDTH-1:0] o_field_out,
	output wire [pat_pkg::DATA_WIDTH-1:0] o_acc,
	output wire [pat_pkg::DATA_WIDTH-1:0] o_outputs
);

	wire [pat_pkg::DATA_WIDTH-1:0] offset;
	wire [DMEM_ADR_WIDTH-1:0] mem_rd_adr;
	wire [pat_pkg::DATA_WIDTH-1:0] mem_rd_data;
	pat_pkg::alu_op_e alu_op;
	wire [pat_pkg::DATA_WIDTH-1:0] operand_b;
	wire [pat_pkg::DATA_WIDTH-1:0] field_value;
	wire [pat_pkg::DATA_WIDTH-1:0] imm;
	wire dest_acc;
	wire dest_field;
	wire store;
	wire out_en;
	wire setb;
	wire test;
	pat_pkg::src_e src;
	pat_pkg::cond_e cond;
	wire field_sel;	// from commit back to field sampling
	wire [pat_pkg::DATA_WIDTH-1:0] acc_result;
	wire [pat_pkg::DATA_WIDTH-1:0] field_result;
	wire mem_we;
	wire [DMEM_ADR_WIDTH-1:0] mem_wr_adr;
	wire [pat_pkg::DATA_WIDTH-1:0] mem_wr_data;

	pat_decoder #(
		.DMEM_ADR_WIDTH(DMEM_ADR_WIDTH),
		.FIELD_LATENCY(FIELD_LATENCY)
	) decoder (
		.clk(clk), .reset(reset),
		.i_instruction(i_instruction),
		.i_mem_data(mem_rd_data),
		.i_field_in_low(i_field_in_low), .i_field_in_high(i_field_in_high),
		.i_field_sel(field_sel),
		.o_branch(o_jump), .o_offset(offset),
		.o_mem_rd_adr(mem_rd_adr),
		.o_alu_op(alu_op), .o_operand_b(operand_b), .o_field_value(field_value),
		.o_dest_acc(dest_acc), .o_dest_field(dest_field),
		.o_store(store), .o_out(out_en), .o_setb(setb), .o_test(test),
		.o_src(src), .o_cond(cond), .o_imm(imm),
		.o_fieldp(o_fieldp), .o_fieldwp(o_fieldwp)
	);

	pat_program_counter #(.I_ADR_WIDTH(I_ADR_WIDTH)) pc (
		.clk(clk), .reset(reset),
		.i_branch(o_jump), .i_offset(offset),
		.o_pc(o_pc)
	);

	pat_data_mem #(.DMEM_ADR_WIDTH(DMEM_ADR_WIDTH)) dmem (
		.clk(clk),
		.i_rd_adr(mem_rd_adr), .o_rd_data(mem_rd_data),
		.i_we(mem_we), .i_wr_adr(mem_wr_adr), .i_wr_data(mem_wr_data)
	);

	// acc side works on the live accumulator, field side on the sampled word
	pat_alu acc_alu (
		.i_a(o_acc), .i_b(operand_b), .i_op(alu_op),
		.o_y(acc_result)
	);

	pat_alu field_alu (
		.i_a(field_value), .i_b(operand_b), .i_op(alu_op),
		.o_y(field_result)
	);

	pat_commit #(.DMEM_ADR_WIDTH(DMEM_ADR_WIDTH)) commit (
		.clk(clk), .reset(reset),
		.i_acc_result(acc_result), .i_field_result(field_result),
		.i_field_value(field_value), .i_inputs(i_inputs),
		.i_dest_acc(dest_acc), .i_dest_field(dest_field),
		.i_store(store), .i_out(out_en), .i_setb(setb), .i_test(test),
		.i_src(src), .i_cond(cond), .i_imm(imm),
		.o_acc(o_acc), .o_field_out(o_field_out),
		.o_field_we_low(o_field_we_low), .o_field_we_high(o_field_we_high),
		.o_field_sel(field_sel), .o_bufp(o_bufp), .o_outputs(o_outputs),
		.o_mem_we(mem_we), .o_mem_wr_adr(mem_wr_adr), .o_mem_wr_data(mem_wr_data)
	);

endmodule

`default_nettype wire

// ==== tests/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

// free running clock, reset held high for the first cycles
module tb_clock #(
	parameter int RESET_CYCLES = 16
) (
	output logic clk,
	output logic reset
);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;	// 4 ns period
	end

	initial
	begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;	// released on a falling edge like every other input
	end

endmodule

`default_nettype wire

// ==== tests/tb_pat.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_pat;

	localparam int I_ADR_WIDTH = 10;
	localparam int DMEM_ADR_WIDTH = 3;
	localparam int FIELD_LATENCY = 4;
	localparam int HIST = FIELD_LATENCY + 3;	// stage 1 up to the write pointer tap
	localparam int TIMEOUT = 100;	// cycles

	wire clk;
	wire reset;
	logic [pat_pkg::INSTR_WIDTH-1:0] i_instruction;
	logic [pat_pkg::DATA_WIDTH-1:0] i_field_in_low;
	logic [pat_pkg::DATA_WIDTH-1:0] i_field_in_high;
	logic [pat_pkg::DATA_WIDTH-1:0] i_inputs;
	wire [I_ADR_WIDTH-1:0] o_pc;
	wire o_jump;
	wire [pat_pkg::BUFP_WIDTH-1:0] o_bufp;
	wire [pat_pkg::FIELDP_WIDTH-1:0] o_fieldp;
	wire [pat_pkg::FIELDP_WIDTH-1:0] o_fieldwp;
	wire o_field_we_low;
	wire o_field_we_high;
	wire [pat_pkg::DATA_WIDTH-1:0] o_field_out;
	wire [pat_pkg::DATA_WIDTH-1:0] o_acc;
	wire [pat_pkg::DATA_WIDTH-1:0] o_outputs;

	// ==============================
	// reference model state
	// ==============================
	logic [7:0] acc_m;
	logic [7:0] fout_m;
	logic [7:0] outputs_m;
	logic [7:0] mem_m [8];	// never reset just like the ram
	logic z_m;
	logic n_m;
	logic sel_m;	// 1 reads the high buffer
	logic we_lo_m;
	logic we_hi_m;
	logic [2:0] bufp_m;
	logic [I_ADR_WIDTH-1:0] pc_m;
	logic [pat_pkg::INSTR_WIDTH-1:0] hist [HIST];	// hist[0] sits in stage 1
	logic [7:0] fv_stage2;	// field word sampled for the stage 2 instruction
	logic [7:0] fv_commit;	// field word of the committing instruction
	logic [31:0] seed = 32'h4b39_2183;
	int error_count = 0;

	tb_clock clock_gen (.clk(clk), .reset(reset));

	pat_core #(
		.I_ADR_WIDTH(I_ADR_WIDTH),
		.DMEM_ADR_WIDTH(DMEM_ADR_WIDTH),
		.FIELD_LATENCY(FIELD_LATENCY)
	) UUT (
		.clk(clk), .reset(reset),
		.i_instruction(i_instruction),
		.i_field_in_low(i_field_in_low), .i_field_in_high(i_field_in_high),
		.i_inputs(i_inputs),
		.o_pc(o_pc), .o_jump(o_jump), .o_bufp(o_bufp),
		.o_fieldp(o_fieldp), .o_fieldwp(o_fieldwp),
		.o_field_we_low(o_field_we_low), .o_field_we_high(o_field_we_high),
		.o_field_out(o_field_out), .o_acc(o_acc), .o_outputs(o_outputs)
	);

	// lcg step that returns its better upper bits
	function automatic logic [7:0] next_random();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed[23:16];
	endfunction

	// ==============================
	// instruction builders
	// ==============================
	function automatic logic [19:0] make_i8(input logic fop, input logic [1:0] cond,
		input logic [3:0] op, input logic [7:0] imm);
		logic [7:0] fp;
		fp = next_random();	// random field pointer on every word
		return {fp[4:0], cond, fop, op, imm};
	endfunction

	function automatic logic [19:0] make_i3(input logic fop, input logic [1:0] cond,
		input logic [3:0] op, input logic [3:0] imm4);
		return make_i8(fop, cond, 4'hf, {op, imm4});
	endfunction

	function automatic logic [19:0] make_i0(input logic fop, input logic [1:0] cond,
		input logic [3:0] op);
		return make_i3(fop, cond, 4'hf, op);
	endfunction

	function automatic logic [19:0] random_alu(input logic fop, input logic [1:0] cond);
		logic [7:0] r;
		logic [7:0] imm;
		r = next_random();
		imm = next_random();
		case (r % 9)
			0: return make_i8(fop, cond, pat_pkg::I8_OR, imm);
			1: return make_i8(fop, cond, pat_pkg::I8_AND, imm);
			2: return make_i8(fop, cond, pat_pkg::I8_ADD, imm);
			3: return make_i8(fop, cond, pat_pkg::I8_SUB, imm);
			4: return make_i3(fop, cond, pat_pkg::I3_SHL, imm[3:0]);
			5: return make_i3(fop, cond, pat_pkg::I3_SHLO, imm[3:0]);
			6: return make_i3(fop, cond, pat_pkg::I3_SHR, imm[3:0]);
			7: return make_i3(fop, cond, pat_pkg::I3_ASR, imm[3:0]);
			default: return make_i0(fop, cond, pat_pkg::I0_NOT);
		endcase
	endfunction

	function automatic logic [19:0] random_mem(input logic fop);
		logic [7:0] r;
		logic [7:0] adr;
		r = next_random();
		adr = next_random();
		case (r % 5)
			0: return make_i8(fop, pat_pkg::COND_ALWAYS, pat_pkg::I8_LDM, adr);
			1: return make_i8(fop, pat_pkg::COND_ALWAYS, pat_pkg::I8_ADDM, adr);
			2: return make_i8(fop, pat_pkg::COND_ALWAYS, pat_pkg::I8_SUBM, adr);
			3: return make_i8(fop, pat_pkg::COND_ALWAYS, pat_pkg::I8_ORM, adr);
			default: return make_i8(fop, pat_pkg::COND_ALWAYS, pat_pkg::I8_ANDM, adr);
		endcase
	endfunction

	// any op but memory ops and setb under any condition
	function automatic logic [19:0] random_mix();
		logic [7:0] r;
		logic [7:0] c;
		logic [7:0] imm;
		r = next_random();
		c = next_random();
		imm = next_random();
		case (r % 7)
			0, 1: return random_alu(c[2], c[1:0]);
			2: return make_i8(c[2], c[1:0], pat_pkg::I8_LDI, imm);
			3: return make_i0(c[2], c[1:0], pat_pkg::I0_TEST);
			4: return make_i0(c[2], c[1:0], pat_pkg::I0_MOV);
			5: return make_i3(c[2], c[1:0], r[7] ? pat_pkg::I3_IN : pat_pkg::I3_OUT, imm[3:0]);
			default: return make_i8(1'b0, pat_pkg::COND_ALWAYS, pat_pkg::I8_BF, imm);
		endcase
	endfunction

	function automatic logic is_branch(input logic [19:0] ins);
		return ins[11:8] == pat_pkg::I8_BF;
	endfunction

	// ==============================
	// reference model for one instruction at its commit
	// ==============================
	function automatic void apply_model(input logic [19:0] ins, input logic [7:0] fv);
		logic [7:0] imm;
		logic [3:0] op8;
		logic [3:0] op3;
		logic [3:0] op0;
		logic [2:0] sh;
		logic fop;
		logic ok;
		logic wr;
		logic [7:0] a;
		logic [7:0] m;
		logic [7:0] res;
		logic [15:0] wide;
		imm = ins[7:0];
		op8 = ins[11:8];
		op3 = imm[7:4];
		op0 = imm[3:0];
		sh = imm[2:0];
		fop = ins[12];
		a = fop ? fv : acc_m;	// each side has its own operand a
		m = mem_m[imm[2:0]];
		ok = (ins[14:13] == 2'd1) ? n_m : (ins[14:13] == 2'd2) ? z_m : 1'b1;
		wr = 1'b0;
		res = 8'd0;
		wide = 16'd0;
		we_lo_m = 1'b0;
		we_hi_m = 1'b0;
		if (!ok)
			return;
		if (op8 != 4'hf)
		begin
			wr = 1'b1;
			case (op8)
				pat_pkg::I8_OR: res = a | imm;
				pat_pkg::I8_AND: res = a & imm;
				pat_pkg::I8_ADD: res = a + imm;
				pat_pkg::I8_SUB: res = a - imm;
				pat_pkg::I8_ORM: res = a | m;
				pat_pkg::I8_ANDM: res = a & m;
				pat_pkg::I8_ADDM: res = a + m;
				pat_pkg::I8_SUBM: res = a - m;
				pat_pkg::I8_LDI: res = imm;
				pat_pkg::I8_LDM: res = m;
				pat_pkg::I8_STM:
				begin
					wr = 1'b0;
					mem_m[imm[2:0]] = a;	// field word on a field op
				end
				default: wr = 1'b0;	// bf only moves the pc
			endcase
		end
		else if (op3 != 4'hf)
		begin
			wr = 1'b1;
			case (op3)
				pat_pkg::I3_SHL: res = a << sh;
				pat_pkg::I3_SHLO:
				begin
					wide = {a, 8'hff} << sh;	// ones shift in from below
					res = wide[15:8];
				end
				pat_pkg::I3_SHR: res = a >> sh;
				pat_pkg::I3_ASR:
				begin
					wide = {{8{a[7]}}, a} >> sh;
					res = wide[7:0];
				end
				pat_pkg::I3_IN: res = i_inputs;
				pat_pkg::I3_OUT:
				begin
					wr = 1'b0;
					outputs_m = acc_m;
				end
				pat_pkg::I3_SETB:
				begin
					wr = 1'b0;
					bufp_m = imm[2:0];
					sel_m = imm[3];
				end
				default: wr = 1'b0;
			endcase
		end
		else
		begin
			wr = 1'b1;
			case (op0)
				pat_pkg::I0_NOT: res = ~a;
				pat_pkg::I0_MOV: res = fop ? acc_m : fv;	// value from the other side
				pat_pkg::I0_TEST:
				begin
					wr = 1'b0;
					z_m = (a == 8'd0);
					n_m = a[7];
				end
				default: wr = 1'b0;
			endcase
		end
		if (wr && fop)
		begin
			fout_m = res;
			we_lo_m = !sel_m;
			we_hi_m = sel_m;
		end
		else if (wr)
			acc_m = res;
	endfunction

	task automatic check_equal(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			error_count++;
			$display("[ERROR] %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
			$display("TESTS FAILED");
			$fatal(1, "mismatch on %s", what);
		end
	endtask

	// returns just after the first rising edge out of reset
	task automatic wait_reset_release();
		int cycles;
		cycles = 0;
		@(posedge clk);
		while (reset)
		begin
			cycles++;
			if (cycles > TIMEOUT)
			begin
				$display("reset was never released");
				$display("TESTS FAILED");
				$fatal(1, "reset timeout");
			end
			@(posedge clk);
		end
	endtask

	// new instruction and fresh input words on each falling edge
	task automatic issue(input logic [19:0] ins);
		@(negedge clk);
		i_instruction = ins;
		i_inputs = next_random();
		i_field_in_low = next_random();
		i_field_in_high = ~i_field_in_low;	// the two buffers always differ
	endtask

	// ==============================
	// compare process
	// ==============================
	initial
	begin : compare_process
		acc_m = 8'd0;
		fout_m = 8'd0;
		outputs_m = 8'd0;
		z_m = 1'b0;
		n_m = 1'b0;
		sel_m = 1'b0;
		bufp_m = 3'd0;
		pc_m = '0;
		fv_stage2 = 8'd0;
		for (int i = 0; i < HIST; i++)
			hist[i] = pat_pkg::INSTR_NOP;
		wait_reset_release();
		forever
		begin
			// pc moves on the word that was in stage 1 up to this edge
			pc_m = pc_m + (is_branch(hist[0]) ?
				I_ADR_WIDTH'($signed(hist[0][7:0])) : I_ADR_WIDTH'(1));
			for (int i = HIST - 1; i > 0; i--)
				hist[i] = hist[i-1];
			hist[0] = i_instruction;
			// field word is taken at the stage 2 edge with the select before it
			fv_commit = fv_stage2;
			fv_stage2 = sel_m ? i_field_in_high : i_field_in_low;
			apply_model(hist[2], fv_commit);	// committed two edges after issue
			@(negedge clk);
			check_equal("o_pc", 32'(o_pc), 32'(pc_m));
			check_equal("o_jump", 32'(o_jump), 32'(is_branch(hist[0])));
			check_equal("o_fieldp", 32'(o_fieldp), 32'(hist[1][19:15]));
			check_equal("o_fieldwp", 32'(o_fieldwp), 32'(hist[HIST-1][19:15]));
			check_equal("o_acc", 32'(o_acc), 32'(acc_m));
			check_equal("o_field_out", 32'(o_field_out), 32'(fout_m));
			check_equal("o_field_we_low", 32'(o_field_we_low), 32'(we_lo_m));
			check_equal("o_field_we_high", 32'(o_field_we_high), 32'(we_hi_m));
			check_equal("o_bufp", 32'(o_bufp), 32'(bufp_m));
			check_equal("o_outputs", 32'(o_outputs), 32'(outputs_m));
			@(posedge clk);
		end
	end

	// ==============================
	// stimulus
	// ==============================
	initial
	begin : stimulus
		logic [7:0] v;
		i_instruction = pat_pkg::INSTR_NOP;
		i_inputs = next_random();
		i_field_in_low = next_random();
		i_field_in_high = ~i_field_in_low;
		wait_reset_release();
		repeat (4) issue(pat_pkg::INSTR_NOP);	// idle while the pc just counts

		// acc arithmetic and shifts
		repeat (30)
		begin
			issue(make_i8(1'b0, pat_pkg::COND_ALWAYS, pat_pkg::I8_LDI, next_random()));
			repeat (3) issue(random_alu(1'b0, pat_pkg::COND_ALWAYS));
		end

		// fill the whole ram first and then store and load with a gap
		for (int a = 0; a < 8; a++)
		begin
			issue(make_i8(1'b0, pat_pkg::COND_ALWAYS, pat_pkg::I8_LDI, next_random()));
			issue(make_i8(1'b0, pat_pkg::COND_ALWAYS, pat_pkg::I8_STM, 8'(a)));
		end
		issue(pat_pkg::INSTR_NOP);
		repeat (20)
		begin
			v = next_random();
			issue(make_i8(1'b0, pat_pkg::COND_ALWAYS, pat_pkg::I8_LDI, next_random()));
			issue(make_i8(v[6], pat_pkg::COND_ALWAYS, pat_pkg::I8_STM, next_random()));
			issue(pat_pkg::INSTR_NOP);	// store lands before the next read
			issue(random_mem(v[5]));
			issue(random_mem(v[4]));
		end

		// flags on zero, negative and positive values
		for (int t = 0; t < 3; t++)
		begin
			v = next_random();
			case (t)
				0: v = 8'h00;
				1: v = v | 8'h80;
				default: v = (v & 8'h7f) | 8'h01;
			endcase
			issue(make_i8(1'b0, pat_pkg::COND_ALWAYS, pat_pkg::I8_LDI, v));
			issue(make_i0(1'b0, pat_pkg::COND_ALWAYS, pat_pkg::I0_TEST));
			issue(make_i8(1'b0, pat_pkg::COND_NEG, pat_pkg::I8_LDI, next_random()));
			issue(make_i8(1'b0, pat_pkg::COND_ZERO, pat_pkg::I8_LDI, next_random()));
			issue(make_i8(1'b0, 2'd3, pat_pkg::I8_LDI, next_random()));
		end

		// forward and backward branches
		issue(make_i8(1'b0, pat_pkg::COND_ALWAYS, pat_pkg::I8_BF, 8'd5));
		issue(pat_pkg::INSTR_NOP);
		issue(make_i8(1'b0, pat_pkg::COND_ALWAYS, pat_pkg::I8_BF, 8'hfd));
		issue(make_i8(1'b0, pat_pkg::COND_ALWAYS, pat_pkg::I8_BF, 8'h80));
		issue(pat_pkg::INSTR_NOP);

		// low buffer and then high buffer
		for (int s = 0; s < 2; s++)
		begin
			v = next_random();
			issue(make_i3(1'b0, pat_pkg::COND_ALWAYS, pat_pkg::I3_SETB, {s[0], v[2:0]}));
			issue(pat_pkg::INSTR_NOP);	// new select reaches sampling
			repeat (6) issue(random_alu(1'b1, pat_pkg::COND_ALWAYS));
			issue(make_i8(1'b1, pat_pkg::COND_ALWAYS, pat_pkg::I8_LDI, next_random()));
			issue(make_i0(1'b0, pat_pkg::COND_ALWAYS, pat_pkg::I0_MOV));
			issue(make_i8(1'b0, pat_pkg::COND_ALWAYS, pat_pkg::I8_LDI, next_random()));
			issue(make_i0(1'b1, pat_pkg::COND_ALWAYS, pat_pkg::I0_MOV));
			issue(make_i3(1'b0, pat_pkg::COND_ALWAYS, pat_pkg::I3_IN, v[3:0]));
			issue(make_i3(1'b1, pat_pkg::COND_ALWAYS, pat_pkg::I3_IN, v[7:4]));
			issue(make_i3(1'b0, pat_pkg::COND_ALWAYS, pat_pkg::I3_OUT, v[3:0]));
			issue(make_i0(1'b1, pat_pkg::COND_ALWAYS, pat_pkg::I0_TEST));
			issue(make_i8(1'b0, pat_pkg::COND_NEG, pat_pkg::I8_LDI, next_random()));
			issue(make_i8(1'b1, pat_pkg::COND_ZERO, pat_pkg::I8_LDI, next_random()));
		end

		repeat (200) issue(random_mix());
		repeat (HIST + 2) issue(pat_pkg::INSTR_NOP);	// drain the pipe
		@(posedge clk);
		if (error_count == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
rtl/pat_pkg.sv
rtl/pat_alu.sv
rtl/pat_data_mem.sv
rtl/pat_program_counter.sv
rtl/pat_decoder.sv
rtl/pat_commit.sv
rtl/pat_core.sv
tests/tb_clock.sv
tests/tb_pat.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the pat_core testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -j 0 --top-module tb_pat \
	-f flist.f --Mdir "$BUILD_DIR" -o tb_pat
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$BUILD_DIR/tb_pat" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^TESTS PASSED$" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1
